//--- vlog.f
sdmacBusPkg.sv
sdmacRegPkg.sv
dmaCtrlIf.sv
fifoPortIf.sv
dmaCtrlRegs.sv
cpuBusSm.sv
dmaFifo.sv
sdmacTop.sv
tbSdmac.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = tbSdmac
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Finished with no errors" $(LOG)

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tbSdmac.sv
`timescale 1ns/1ps

module tbSdmac;

    // Run length limits in BCLK cycles
    localparam int NUM_TESTS    = 7;
    localparam int MAX_BURST    = 16;
    localparam int MAX_WAIT     = 3;
    localparam int BUS_OVERHEAD = 8;
    localparam int WAIT_LIMIT   = MAX_BURST * (MAX_WAIT + BUS_OVERHEAD) * 4;
    localparam int WATCHDOG_CYC = NUM_TESTS * WAIT_LIMIT + 2000;

    // Slave port behavior
    localparam int MODE_DSACK32 = 0;
    localparam int MODE_STERM   = 1;
    localparam int MODE_16      = 2;

    logic        BCLK;
    logic        CCRESET_;
    logic        regWr;
    logic [1:0]  regAddr;
    logic [31:0] regWrData;
    logic [31:0] regRdData;
    logic        scsiPush;
    logic [31:0] scsiWrData;
    logic        scsiPop;
    logic [31:0] scsiRdData;
    logic        BREQ;
    logic        BGACK;
    logic        BGRANT_ = 1'b1;
    logic        AS_;
    logic        DS_;
    logic        RW;
    logic        SIZE1;
    logic [31:0] busAddr;
    logic [31:0] busDataOut;
    logic [31:0] busDataIn = '0;
    logic [1:0]  DSACK_ = 2'b11;
    logic        STERM_ = 1'b1;

    // Slave memory with reads from readMem and writes into slaveMem
    logic [31:0] readMem [64];
    logic [31:0] slaveMem [64];
    int          portMode;
    int          grantDly = 0;
    int          waitLeft = 0;
    logic        acking = 1'b0;
    int unsigned waitSeed = 32'd77404;
    int unsigned wordSeed;

    logic [31:0] sentWords [$];
    int          errCount;
    int          busErrCount = 0;
    int          passCount;
    int          failCount;
    int          testStartErr;

    logic        bgackPrev = 1'b0;
    logic        grantPrev_ = 1'b1;
    logic        asPrev_ = 1'b1;
    logic [31:0] addrPrev = '0;
    logic        rwPrev = 1'b1;
    logic [31:0] xferStart = '0;

    sdmacTop dut_i (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .regWr      (regWr),
        .regAddr    (regAddr),
        .regWrData  (regWrData),
        .regRdData  (regRdData),
        .scsiPush   (scsiPush),
        .scsiWrData (scsiWrData),
        .scsiPop    (scsiPop),
        .scsiRdData (scsiRdData),
        .BREQ       (BREQ),
        .BGACK      (BGACK),
        .BGRANT_    (BGRANT_),
        .AS_        (AS_),
        .DS_        (DS_),
        .RW         (RW),
        .SIZE1      (SIZE1),
        .busAddr    (busAddr),
        .busDataOut (busDataOut),
        .busDataIn  (busDataIn),
        .DSACK_     (DSACK_),
        .STERM_     (STERM_)
    );

    initial begin
        BCLK = 1'b0;
        forever #10 BCLK = ~BCLK;
    end

    function automatic int unsigned nextLcg(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Background memory contents spread over the whole address
    function automatic logic [31:0] fillPattern(input logic [31:0] addr);
        return (addr * 32'h9E3779B1) ^ 32'h5A5A_0000;
    endfunction

    // Reference longword expected at addr once sentWords is moved from startAddr on
    function automatic logic [31:0] refMemWord(input logic [31:0] startAddr,
                                               input logic [31:0] addr);
        int k;
        k = int'((addr - startAddr) >> 2);
        if (addr >= startAddr && k < sentWords.size()) begin
            return sentWords[k];
        end
        return fillPattern(addr);
    endfunction

    function automatic logic [31:0] ctrlWord(input logic ena, input logic dir, input logic fl);
        logic [31:0] w;
        w = '0;
        w[sdmacRegPkg::CTRL_ENA]   = ena;
        w[sdmacRegPkg::CTRL_DIR]   = dir;
        w[sdmacRegPkg::CTRL_FLUSH] = fl;
        return w;
    endfunction

    // Bus slave granting two cycles after BREQ and adding random wait states
    always @(posedge BCLK) begin
        if (BGACK) begin
            BGRANT_  <= 1'b1;
            grantDly <= 0;
        end else if (BREQ) begin
            if (grantDly >= 1) begin
                BGRANT_ <= 1'b0;
            end
            grantDly <= grantDly + 1;
        end else begin
            grantDly <= 0;
        end

        if (AS_) begin
            DSACK_   <= 2'b11;
            STERM_   <= 1'b1;
            acking   <= 1'b0;
            waitSeed = nextLcg(waitSeed);
            waitLeft <= int'((waitSeed >> 16) % (MAX_WAIT + 1));
        end else if (!acking) begin
            if (waitLeft == 0) begin
                acking <= 1'b1;
                case (portMode)
                    MODE_STERM: STERM_ <= 1'b0;
                    MODE_16:    DSACK_ <= 2'b01;
                    default:    DSACK_ <= 2'b00;
                endcase
                if (RW) begin
                    if (portMode == MODE_16) begin
                        busDataIn <= busAddr[1] ? {readMem[busAddr[7:2]][15:0], 16'h0000} :
                                                  {readMem[busAddr[7:2]][31:16], 16'h0000};
                    end else begin
                        busDataIn <= readMem[busAddr[7:2]];
                    end
                end else if (portMode == MODE_16) begin
                    // Big-endian halves with the upper half at the even address
                    if (busAddr[1]) begin
                        slaveMem[busAddr[7:2]][15:0] = busDataOut[31:16];
                    end else begin
                        slaveMem[busAddr[7:2]][31:16] = busDataOut[31:16];
                    end
                end else begin
                    slaveMem[busAddr[7:2]] = busDataOut;
                end
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end
    end

    // Bus discipline monitor
    always @(negedge BCLK) begin
        if (CCRESET_) begin
            if (!AS_ && !BGACK) begin
                $display("AS_ is low while BGACK is low at %0t", $time);
                busErrCount <= busErrCount + 1;
            end
            if (AS_ !== DS_) begin
                $display("DS_ does not follow AS_ at %0t", $time);
                busErrCount <= busErrCount + 1;
            end
            if (BGACK && !bgackPrev && grantPrev_) begin
                $display("BGACK rose without a bus grant at %0t", $time);
                busErrCount <= busErrCount + 1;
            end
            if (!AS_ && !asPrev_ && (busAddr != addrPrev || RW != rwPrev)) begin
                $display("Address or RW changed during a bus cycle at %0t", $time);
                busErrCount <= busErrCount + 1;
            end
            // The first strobe of a transfer goes out before the port size is known
            if (!AS_ && busAddr != xferStart && SIZE1 != (portMode == MODE_16)) begin
                $display("SIZE1 does not match the port size at %0t", $time);
                busErrCount <= busErrCount + 1;
            end
        end
        bgackPrev  <= BGACK;
        grantPrev_ <= BGRANT_;
        asPrev_    <= AS_;
        addrPrev   <= busAddr;
        rwPrev     <= RW;
    end

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            errCount++;
        end
    endtask

    task automatic writeReg(input logic [1:0] a, input logic [31:0] d);
        @(posedge BCLK);
        regWr     <= 1'b1;
        regAddr   <= a;
        regWrData <= d;
        @(posedge BCLK);
        regWr <= 1'b0;
    endtask

    task automatic readReg(input logic [1:0] a, output logic [31:0] d);
        @(posedge BCLK);
        regAddr <= a;
        @(negedge BCLK);
        d = regRdData;
    endtask

    task automatic pushScsi(input logic [31:0] w);
        @(posedge BCLK);
        scsiPush   <= 1'b1;
        scsiWrData <= w;
        @(posedge BCLK);
        scsiPush <= 1'b0;
    endtask

    task automatic popScsi();
        @(posedge BCLK);
        scsiPop <= 1'b1;
        @(posedge BCLK);
        scsiPop <= 1'b0;
    endtask

    task automatic beginTest();
        testStartErr = errCount + busErrCount;
    endtask

    task automatic endTest(input string name);
        if (errCount + busErrCount == testStartErr) begin
            $display("test %s: passed", name);
            passCount++;
        end else begin
            $display("test %s: failed", name);
            failCount++;
        end
    endtask

    task automatic waitFlushDone(input string name);
        int n;
        @(posedge BCLK);
        regAddr <= sdmacRegPkg::REG_STATUS;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge BCLK);
            if (regRdData[sdmacRegPkg::STAT_FLUSHDONE] && !BGACK) begin
                return;
            end
        end
        $display("Flush did not complete in test %s", name);
        errCount++;
    endtask

    // FIFO to memory with flush
    task automatic runWrite(input string name, input int mode, input logic [31:0] start,
                            input int n);
        sdmacBusPkg::dmaWord_u expWord;
        sdmacBusPkg::dmaWord_u gotWord;
        logic [31:0]           rd;
        logic [31:0]           a;
        int                    k;
        beginTest();
        portMode  = mode;
        xferStart = start;
        sentWords.delete();
        writeReg(sdmacRegPkg::REG_CTRL, '0);
        writeReg(sdmacRegPkg::REG_ADDR, start);
        for (k = 0; k < n; k++) begin
            wordSeed = nextLcg(wordSeed);
            sentWords.push_back(wordSeed);
            pushScsi(wordSeed);
        end
        writeReg(sdmacRegPkg::REG_CTRL, ctrlWord(1'b1, 1'b1, 1'b1));
        waitFlushDone(name);
        writeReg(sdmacRegPkg::REG_CTRL, '0);
        for (k = 0; k < n; k++) begin
            a                = start + 4 * k;
            expWord.longWord = refMemWord(start, a);
            gotWord.longWord = slaveMem[a[7:2]];
            if (mode == MODE_16) begin
                checkValue(name, {16'h0, expWord.half.hi}, {16'h0, gotWord.half.hi});
                checkValue(name, {16'h0, expWord.half.lo}, {16'h0, gotWord.half.lo});
            end else begin
                checkValue(name, expWord.longWord, gotWord.longWord);
            end
        end
        readReg(sdmacRegPkg::REG_ADDR, rd);
        checkValue(name, start + 4 * n, rd);
        readReg(sdmacRegPkg::REG_STATUS, rd);
        checkValue(name, 32'(1) << sdmacRegPkg::STAT_FLUSHDONE, rd);
        endTest(name);
    endtask

    // Memory to FIFO with one fill of eight words
    task automatic runRead(input string name, input int mode, input logic [31:0] start);
        logic [31:0] rd;
        int          k;
        int          n;
        beginTest();
        portMode  = mode;
        xferStart = start;
        sentWords.delete();
        for (k = 0; k < 8; k++) begin
            wordSeed = nextLcg(wordSeed);
            sentWords.push_back(wordSeed);
            readMem[start[7:2] + k] = wordSeed;
        end
        writeReg(sdmacRegPkg::REG_CTRL, '0);
        writeReg(sdmacRegPkg::REG_ADDR, start);
        writeReg(sdmacRegPkg::REG_CTRL, ctrlWord(1'b1, 1'b0, 1'b0));
        @(posedge BCLK);
        regAddr <= sdmacRegPkg::REG_STATUS;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge BCLK);
            if (regRdData[3:0] == 4'd8 && !BGACK) begin
                break;
            end
        end
        if (n == WAIT_LIMIT) begin
            $display("FIFO did not fill in test %s", name);
            errCount++;
        end
        writeReg(sdmacRegPkg::REG_CTRL, '0);
        for (k = 0; k < 8; k++) begin
            @(negedge BCLK);
            checkValue(name, refMemWord(start, start + 4 * k), scsiRdData);
            popScsi();
        end
        readReg(sdmacRegPkg::REG_ADDR, rd);
        checkValue(name, start + 32, rd);
        readReg(sdmacRegPkg::REG_STATUS, rd);
        checkValue(name, 32'(0), {28'h0, rd[3:0]});
        endTest(name);
    endtask

    task automatic runRegs();
        logic [31:0] rd;
        beginTest();
        writeReg(sdmacRegPkg::REG_CTRL, ctrlWord(1'b0, 1'b1, 1'b1));
        readReg(sdmacRegPkg::REG_CTRL, rd);
        checkValue("regReadback", ctrlWord(1'b0, 1'b1, 1'b1), rd);
        writeReg(sdmacRegPkg::REG_ADDR, 32'h1234_5678);
        readReg(sdmacRegPkg::REG_ADDR, rd);
        checkValue("regReadback", 32'h1234_5678, rd);
        pushScsi(32'hCAFE_0001);
        pushScsi(32'hCAFE_0002);
        readReg(sdmacRegPkg::REG_STATUS, rd);
        checkValue("regReadback", 32'd2, rd);
        popScsi();
        popScsi();
        readReg(sdmacRegPkg::REG_STATUS, rd);
        checkValue("regReadback", 32'd0, rd);
        writeReg(sdmacRegPkg::REG_CTRL, '0);
        endTest("regReadback");
    endtask

    task automatic runThreshold();
        logic [31:0] rd;
        int          k;
        beginTest();
        portMode  = MODE_DSACK32;
        xferStart = 32'hE0;
        sentWords.delete();
        writeReg(sdmacRegPkg::REG_ADDR, 32'hE0);
        for (k = 0; k < 3; k++) begin
            wordSeed = nextLcg(wordSeed);
            sentWords.push_back(wordSeed);
            pushScsi(wordSeed);
        end
        writeReg(sdmacRegPkg::REG_CTRL, ctrlWord(1'b1, 1'b1, 1'b0));
        for (k = 0; k < 50; k++) begin
            @(negedge BCLK);
            if (BREQ) begin
                $display("BREQ rose below the FIFO threshold");
                errCount++;
                break;
            end
        end
        writeReg(sdmacRegPkg::REG_CTRL, ctrlWord(1'b1, 1'b1, 1'b1));
        waitFlushDone("threshFlush");
        writeReg(sdmacRegPkg::REG_CTRL, '0);
        for (k = 0; k < 3; k++) begin
            checkValue("threshFlush", refMemWord(32'hE0, 32'hE0 + 4 * k), slaveMem[56 + k]);
        end
        readReg(sdmacRegPkg::REG_STATUS, rd);
        checkValue("threshFlush", 32'(1) << sdmacRegPkg::STAT_FLUSHDONE, rd);
        endTest("threshFlush");
    endtask

    initial begin
        int i;
        CCRESET_   = 1'b0;
        regWr      = 1'b0;
        regAddr    = '0;
        regWrData  = '0;
        scsiPush   = 1'b0;
        scsiWrData = '0;
        scsiPop    = 1'b0;
        portMode   = MODE_DSACK32;
        wordSeed   = 32'd77404;
        errCount   = 0;
        passCount  = 0;
        failCount  = 0;
        for (i = 0; i < 64; i++) begin
            readMem[i] = fillPattern(32'(i * 4));
        end
        repeat (3) @(posedge BCLK);
        CCRESET_ <= 1'b1;

        runRegs();
        runWrite("write32Dsack", MODE_DSACK32, 32'h40, 6);
        runWrite("write32Sterm", MODE_STERM, 32'h80, 5);
        runWrite("write16", MODE_16, 32'h00, 5);
        runRead("read32", MODE_DSACK32, 32'hA0);
        runRead("read16", MODE_16, 32'hC0);
        runThreshold();

        repeat (2) @(posedge BCLK);
        $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount,
                 errCount + busErrCount);
        if (errCount + busErrCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYC) @(posedge BCLK);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- sdmacTop.sv
`timescale 1ns/1ps

module sdmacTop (
    input  logic                           BCLK,
    input  logic                           CCRESET_,
    // Register port
    input  logic                           regWr,
    input  logic [1:0]                     regAddr,
    input  logic [sdmacBusPkg::DATA_W-1:0] regWrData,
    output logic [sdmacBusPkg::DATA_W-1:0] regRdData,
    // SCSI side
    input  logic                           scsiPush,
    input  logic [sdmacBusPkg::DATA_W-1:0] scsiWrData,
    input  logic                           scsiPop,
    output logic [sdmacBusPkg::DATA_W-1:0] scsiRdData,
    // CPU bus
    output logic                           BREQ,
    output logic                           BGACK,
    input  logic                           BGRANT_,
    output logic                           AS_,
    output logic                           DS_,
    output logic                           RW,
    output logic                           SIZE1,
    output logic [sdmacBusPkg::ADDR_W-1:0] busAddr,
    output logic [sdmacBusPkg::DATA_W-1:0] busDataOut,
    input  logic [sdmacBusPkg::DATA_W-1:0] busDataIn,
    input  logic [1:0]                     DSACK_,
    input  logic                           STERM_
);

    dmaCtrlIf  ctrlBus ();
    fifoPortIf fifoBus ();

    dmaCtrlRegs regs_i (
        .BCLK      (BCLK),
        .CCRESET_  (CCRESET_),
        .regWr     (regWr),
        .regAddr   (regAddr),
        .regWrData (regWrData),
        .regRdData (regRdData),
        .fifoCount (fifoBus.fifoCount),
        .ctrl      (ctrlBus.regs)
    );

    cpuBusSm sm_i (
        .BCLK     (BCLK),
        .CCRESET_ (CCRESET_),
        .BGRANT_  (BGRANT_),
        .DSACK_   (DSACK_),
        .STERM_   (STERM_),
        .BREQ     (BREQ),
        .BGACK    (BGACK),
        .AS_      (AS_),
        .DS_      (DS_),
        .RW       (RW),
        .SIZE1    (SIZE1),
        .busAddr  (busAddr),
        .ctrl     (ctrlBus.sm),
        .fifo     (fifoBus.sm)
    );

    dmaFifo fifo_i (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .scsiPush   (scsiPush),
        .scsiWrData (scsiWrData),
        .scsiPop    (scsiPop),
        .scsiRdData (scsiRdData),
        .busDataIn  (busDataIn),
        .busDataOut (busDataOut),
        .port       (fifoBus.fifo)
    );

endmodule

//--- dmaFifo.sv
`timescale 1ns/1ps

module dmaFifo (
    input  logic                           BCLK,
    input  logic                           CCRESET_,
    input  logic                           scsiPush,
    input  logic [sdmacBusPkg::DATA_W-1:0] scsiWrData,
    input  logic                           scsiPop,
    output logic [sdmacBusPkg::DATA_W-1:0] scsiRdData,
    input  logic [sdmacBusPkg::DATA_W-1:0] busDataIn,
    output logic [sdmacBusPkg::DATA_W-1:0] busDataOut,
    fifoPortIf.fifo                        port
);

    sdmacBusPkg::dmaWord_u mem [sdmacRegPkg::FIFO_DEPTH];
    sdmacBusPkg::dmaWord_u headWord;
    // Read halfwords are assembled here before the push
    sdmacBusPkg::dmaWord_u packWord;

    logic [sdmacRegPkg::PTR_W-1:0] wrPtr;
    logic [sdmacRegPkg::PTR_W-1:0] rdPtr;
    logic [sdmacRegPkg::CNT_W-1:0] count;
    logic                          doPush;
    logic                          doPop;
    logic [sdmacBusPkg::DATA_W-1:0] pushData;

    assign port.fifoEmpty = (count == '0);
    assign port.fifoFull  = (count == sdmacRegPkg::FIFO_DEPTH);
    assign port.fifoCount = count;

    // Pushes to a full FIFO and pops from an empty one are dropped
    assign doPush   = (scsiPush || port.pushFromBus) && !port.fifoFull;
    assign doPop    = (scsiPop || port.popToBus) && !port.fifoEmpty;
    assign pushData = port.pushFromBus ? packWord.longWord : scsiWrData;

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge BCLK) begin
        if (doPush) begin
            mem[wrPtr].longWord <= pushData;
        end
        // A 16-bit port returns its data on the upper lanes
        if (port.latchHigh && port.latchLow) begin
            packWord.longWord <= busDataIn;
        end else if (port.latchHigh) begin
            packWord.half.hi <= busDataIn[sdmacBusPkg::DATA_W-1:sdmacBusPkg::HALF_W];
        end else if (port.latchLow) begin
            packWord.half.lo <= busDataIn[sdmacBusPkg::DATA_W-1:sdmacBusPkg::HALF_W];
        end
    end

    assign headWord   = mem[rdPtr];
    assign scsiRdData = headWord.longWord;

    // Low half goes out on both lanes for the second halfword cycle
    assign busDataOut = port.selHigh ? headWord.longWord :
                        {headWord.half.lo, headWord.half.lo};

endmodule

//--- cpuBusSm.sv
`timescale 1ns/1ps

module cpuBusSm (
    input  logic                           BCLK,
    input  logic                           CCRESET_,
    input  logic                           BGRANT_,
    input  logic [1:0]                     DSACK_,
    input  logic                           STERM_,
    output logic                           BREQ,
    output logic                           BGACK,
    output logic                           AS_,
    output logic                           DS_,
    output logic                           RW,
    output logic                           SIZE1,
    output logic [sdmacBusPkg::ADDR_W-1:0] busAddr,
    dmaCtrlIf.sm                           ctrl,
    fifoPortIf.sm                          fifo
);

    sdmacBusPkg::busState_e state;

    // Bus inputs after one BCLK register
    logic       grantSync_;
    logic [1:0] dsackSync_;
    logic       stermSync_;

    // Set while the low half of a longword is still to go
    logic halfFlag;
    // Port size seen at the last termination
    logic port16;

    logic termSeen;
    logic port32;
    logic halfCyc;
    logic capture;
    logic startCond;
    logic flushEmpty;
    logic moreToWrite;
    logic roomToRead;
    logic keepGoing;
    logic [sdmacRegPkg::CNT_W-1:0] popExt;
    logic [sdmacRegPkg::CNT_W-1:0] pushExt;

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            grantSync_ <= 1'b1;
            dsackSync_ <= 2'b11;
            stermSync_ <= 1'b1;
        end else begin
            grantSync_ <= BGRANT_;
            dsackSync_ <= DSACK_;
            stermSync_ <= STERM_;
        end
    end

    // Termination decode, both DSACK_ low or STERM_ means a 32-bit port
    assign termSeen = !stermSync_ || (dsackSync_ != 2'b11);
    assign port32   = !stermSync_ || (dsackSync_ == 2'b00);
    assign halfCyc  = !port32 || halfFlag;

    // Read data is taken in the cycle the termination shows up
    assign capture        = (state == sdmacBusPkg::stStrobe) && !AS_ && termSeen && RW;
    assign fifo.latchHigh = capture && !halfFlag;
    assign fifo.latchLow  = capture && (halfFlag || !halfCyc);
    assign fifo.selHigh   = !halfFlag;

    assign startCond = ctrl.dmaEna && (ctrl.dmaDir ?
        ((fifo.fifoCount >= sdmacRegPkg::FIFO_THRESH) || (ctrl.flush && !fifo.fifoEmpty)) :
        !fifo.fifoFull);
    assign flushEmpty = ctrl.dmaEna && ctrl.dmaDir && ctrl.flush && fifo.fifoEmpty;

    // Look ahead past the pop or push still in flight during recover
    assign popExt      = {{(sdmacRegPkg::CNT_W-1){1'b0}}, fifo.popToBus};
    assign pushExt     = {{(sdmacRegPkg::CNT_W-1){1'b0}}, fifo.pushFromBus};
    assign moreToWrite = (fifo.fifoCount - popExt) != '0;
    assign roomToRead  = (fifo.fifoCount + pushExt) < sdmacRegPkg::FIFO_DEPTH;
    assign keepGoing   = ctrl.dmaEna && (RW ? roomToRead : moreToWrite);

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state            <= sdmacBusPkg::stIdle;
            BREQ             <= 1'b0;
            BGACK            <= 1'b0;
            AS_              <= 1'b1;
            DS_              <= 1'b1;
            RW               <= 1'b1;
            SIZE1            <= 1'b0;
            busAddr          <= '0;
            halfFlag         <= 1'b0;
            port16           <= 1'b0;
            ctrl.incAddr2    <= 1'b0;
            ctrl.incAddr4    <= 1'b0;
            ctrl.stopFlush   <= 1'b0;
            fifo.popToBus    <= 1'b0;
            fifo.pushFromBus <= 1'b0;
        end else begin
            ctrl.incAddr2    <= 1'b0;
            ctrl.incAddr4    <= 1'b0;
            ctrl.stopFlush   <= 1'b0;
            fifo.popToBus    <= 1'b0;
            fifo.pushFromBus <= 1'b0;

            case (state)
                sdmacBusPkg::stIdle: begin
                    if (startCond) begin
                        BREQ  <= 1'b1;
                        state <= sdmacBusPkg::stRequest;
                    end else if (flushEmpty && !ctrl.stopFlush) begin
                        // Flush with nothing left to move
                        ctrl.stopFlush <= 1'b1;
                    end
                end
                sdmacBusPkg::stRequest: begin
                    if (!grantSync_) begin
                        BREQ  <= 1'b0;
                        BGACK <= 1'b1;
                        state <= sdmacBusPkg::stStart;
                    end
                end
                sdmacBusPkg::stStart: begin
                    busAddr <= ctrl.curAddr;
                    SIZE1   <= halfFlag || port16;
                    // Direction is frozen for the second half
                    if (!halfFlag) begin
                        RW <= !ctrl.dmaDir;
                    end
                    state <= sdmacBusPkg::stStrobe;
                end
                sdmacBusPkg::stStrobe: begin
                    if (AS_) begin
                        AS_ <= 1'b0;
                        DS_ <= 1'b0;
                    end else if (termSeen) begin
                        AS_    <= 1'b1;
                        DS_    <= 1'b1;
                        port16 <= !port32;
                        state  <= sdmacBusPkg::stRecover;
                        if (!halfCyc) begin
                            ctrl.incAddr4    <= 1'b1;
                            fifo.pushFromBus <= RW;
                            fifo.popToBus    <= !RW;
                        end else begin
                            ctrl.incAddr2 <= 1'b1;
                            halfFlag      <= !halfFlag;
                            // Longword done after the low half
                            if (halfFlag) begin
                                fifo.pushFromBus <= RW;
                                fifo.popToBus    <= !RW;
                            end
                        end
                    end
                end
                sdmacBusPkg::stRecover: begin
                    if (halfFlag || keepGoing) begin
                        state <= sdmacBusPkg::stStart;
                    end else begin
                        state <= sdmacBusPkg::stRelease;
                    end
                end
                sdmacBusPkg::stRelease: begin
                    BGACK <= 1'b0;
                    state <= sdmacBusPkg::stIdle;
                    if (flushEmpty) begin
                        ctrl.stopFlush <= 1'b1;
                    end
                end
                default: begin
                    state <= sdmacBusPkg::stIdle;
                end
            endcase
        end
    end

endmodule

//--- dmaCtrlRegs.sv
`timescale 1ns/1ps

module dmaCtrlRegs (
    input  logic                           BCLK,
    input  logic                           CCRESET_,
    input  logic                           regWr,
    input  logic [1:0]                     regAddr,
    input  logic [sdmacBusPkg::DATA_W-1:0] regWrData,
    output logic [sdmacBusPkg::DATA_W-1:0] regRdData,
    input  logic [sdmacRegPkg::CNT_W-1:0]  fifoCount,
    dmaCtrlIf.regs                         ctrl
);

    logic flushDone;
    logic ctrlWr;
    logic addrWr;

    assign ctrlWr = regWr && (regAddr == sdmacRegPkg::REG_CTRL);
    assign addrWr = regWr && (regAddr == sdmacRegPkg::REG_ADDR);

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            ctrl.dmaEna  <= 1'b0;
            ctrl.dmaDir  <= 1'b0;
            ctrl.flush   <= 1'b0;
            ctrl.curAddr <= '0;
            flushDone    <= 1'b0;
        end else begin
            // Flush finished on the bus side
            if (ctrl.stopFlush) begin
                ctrl.flush <= 1'b0;
                flushDone  <= 1'b1;
            end
            // A CPU write to the control register wins over stopFlush
            if (ctrlWr) begin
                ctrl.dmaEna <= regWrData[sdmacRegPkg::CTRL_ENA];
                ctrl.dmaDir <= regWrData[sdmacRegPkg::CTRL_DIR];
                ctrl.flush  <= regWrData[sdmacRegPkg::CTRL_FLUSH];
                if (regWrData[sdmacRegPkg::CTRL_FLUSH]) begin
                    flushDone <= 1'b0;
                end
            end
            // Address counter
            if (addrWr) begin
                ctrl.curAddr <= regWrData;
            end else if (ctrl.incAddr4) begin
                ctrl.curAddr <= ctrl.curAddr + 'd4;
            end else if (ctrl.incAddr2) begin
                ctrl.curAddr <= ctrl.curAddr + 'd2;
            end
        end
    end

    // Read mux
    always_comb begin
        regRdData = '0;
        case (regAddr)
            sdmacRegPkg::REG_CTRL: begin
                regRdData[sdmacRegPkg::CTRL_ENA]   = ctrl.dmaEna;
                regRdData[sdmacRegPkg::CTRL_DIR]   = ctrl.dmaDir;
                regRdData[sdmacRegPkg::CTRL_FLUSH] = ctrl.flush;
            end
            sdmacRegPkg::REG_ADDR: begin
                regRdData = ctrl.curAddr;
            end
            sdmacRegPkg::REG_STATUS: begin
                regRdData[sdmacRegPkg::CNT_W-1:0]      = fifoCount;
                regRdData[sdmacRegPkg::STAT_FLUSHDONE] = flushDone;
            end
            default: begin
                regRdData = '0;
            end
        endcase
    end

endmodule

//--- fifoPortIf.sv
`timescale 1ns/1ps

interface fifoPortIf;

    // Strobes from the bus machine
    logic popToBus;
    logic pushFromBus;

    // Halfword steering
    logic selHigh;
    logic latchHigh;
    logic latchLow;

    // FIFO status
    logic                          fifoEmpty;
    logic                          fifoFull;
    logic [sdmacRegPkg::CNT_W-1:0] fifoCount;

    modport sm (
        output popToBus, pushFromBus,
        output selHigh, latchHigh, latchLow,
        input  fifoEmpty, fifoFull, fifoCount
    );

    modport fifo (
        input  popToBus, pushFromBus,
        input  selHigh, latchHigh, latchLow,
        output fifoEmpty, fifoFull, fifoCount
    );

endinterface

//--- dmaCtrlIf.sv
`timescale 1ns/1ps

interface dmaCtrlIf;

    // Levels from the register block
    logic                           dmaEna;
    logic                           dmaDir;
    logic                           flush;
    logic [sdmacBusPkg::ADDR_W-1:0] curAddr;

    // Single-cycle pulses from the bus machine
    logic incAddr2;
    logic incAddr4;
    logic stopFlush;

    modport regs (
        output dmaEna, dmaDir, flush, curAddr,
        input  incAddr2, incAddr4, stopFlush
    );

    modport sm (
        input  dmaEna, dmaDir, flush, curAddr,
        output incAddr2, incAddr4, stopFlush
    );

endinterface

//--- sdmacRegPkg.sv
package sdmacRegPkg;

    // Register addresses
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_ADDR   = 2'd1;
    localparam logic [1:0] REG_STATUS = 2'd2;

    // Control register bits, DIR set means FIFO to memory
    localparam int CTRL_ENA   = 0;
    localparam int CTRL_DIR   = 1;
    localparam int CTRL_FLUSH = 2;

    // Status register, FIFO count sits in the low CNT_W bits
    localparam int STAT_FLUSHDONE = 4;

    // FIFO sizing
    localparam int CNT_W = 4;
    localparam int PTR_W = 3;
    localparam logic [CNT_W-1:0] FIFO_DEPTH  = 4'd8;
    localparam logic [CNT_W-1:0] FIFO_THRESH = 4'd4;

endpackage

//--- sdmacBusPkg.sv
package sdmacBusPkg;

    // CPU bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int HALF_W = 16;

    // Bus master states
    typedef enum logic [2:0] {
        // Bus released and nothing to do
        stIdle,
        // BREQ out, waiting for grant
        stRequest,
        // Address, RW and SIZE1 driven
        stStart,
        // AS_ and DS_ low until DSACK or STERM
        stStrobe,
        // One idle bus cycle before the next start
        stRecover,
        // BGACK dropped here
        stRelease
    } busState_e;

    // One FIFO entry, used as a longword or as two halfwords
    typedef struct packed {
        logic [HALF_W-1:0] hi;
        logic [HALF_W-1:0] lo;
    } halfPair_s;

    typedef union packed {
        logic [DATA_W-1:0] longWord;
        halfPair_s         half;
    } dmaWord_u;

endpackage
